//--- Makefile
TOP = vmem_map_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- build.f
source/vmem_pkg.sv
source/vmem_map_ram.sv
source/vmem_arbiter.sv
source/vmem_map_loader.sv
source/vmem_translator.sv
source/vmem_map_top.sv
sim/vmem_map_sva.sv
sim/vmem_map_tb.sv

//--- sim/vmem_map_sva.sv
`timescale 1ns/1ps

module vmem_map_sva
(
   input logic clk_a,
   input logic reset,
   input logic wr_grant,
   input logic rd_grant,
   input logic load_strobe,
   input logic load_busy,
   input logic rd_req,
   input logic xlat_done
);

   one_grant: assert property (@(posedge clk_a) disable iff (reset) !(wr_grant && rd_grant))
      else $error("wr_grant and rd_grant high together");

   no_load_while_busy: assert property (@(posedge clk_a) disable iff (reset)
      !(load_strobe && load_busy))
      else $error("load_strobe while load_busy");

   // a lookup waits at most one cycle behind a write, so the second cycle must grant.
   rd_granted: assert property (@(posedge clk_a) disable iff (reset)
      (rd_req && $past(rd_req)) |-> rd_grant)
      else $error("rd_req not granted within 2 cycles");

   done_low_in_reset: assert property (@(posedge clk_a) (reset && $past(reset)) |-> !xlat_done)
      else $error("xlat_done high during reset");

endmodule

bind vmem_map_top vmem_map_sva i_vmem_map_sva (
   .clk_a(clk_a), .reset(reset), .wr_grant(wr_grant), .rd_grant(rd_grant),
   .load_strobe(load_strobe), .load_busy(load_busy), .rd_req(rd_req), .xlat_done(xlat_done)
);

//--- sim/vmem_map_tb.sv
`timescale 1ns/1ps

module vmem_map_tb;

   localparam int page_bits  = vmem_pkg::default_page_bits;
   localparam int vaddr_bits = page_bits + vmem_pkg::offset_bits;
   localparam int paddr_bits = vmem_pkg::frame_bits + vmem_pkg::offset_bits;

   logic                            clk_a;
   logic                            reset;
   logic                            load_strobe;
   logic [page_bits-1:0]            load_page;
   logic [vmem_pkg::entry_bits-1:0] load_entry;
   logic                            load_busy;
   logic                            rb_strobe;
   logic [page_bits-1:0]            rb_page;
   logic                            rb_valid;
   logic [vmem_pkg::entry_bits-1:0] rb_entry;
   logic                            xlat_strobe;
   logic [vaddr_bits-1:0]           xlat_vaddr;
   logic                            xlat_write;
   logic                            xlat_busy;
   logic                            xlat_done;
   logic [paddr_bits-1:0]           xlat_paddr;
   logic                            xlat_fault;

   string ops[$];       // trace lines that carry an operation.
   logic  trace_loaded;

   vmem_map_top #(.page_bits(page_bits)) i_vmem_map_top (
      .clk_a(clk_a), .reset(reset),
      .load_strobe(load_strobe), .load_page(load_page), .load_entry(load_entry),
      .load_busy(load_busy),
      .rb_strobe(rb_strobe), .rb_page(rb_page), .rb_valid(rb_valid), .rb_entry(rb_entry),
      .xlat_strobe(xlat_strobe), .xlat_vaddr(xlat_vaddr), .xlat_write(xlat_write),
      .xlat_busy(xlat_busy), .xlat_done(xlat_done),
      .xlat_paddr(xlat_paddr), .xlat_fault(xlat_fault)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #5 clk_a = ~clk_a;
   end

   // inputs change 1 ns after the rising edge.
   task automatic step();
      @(posedge clk_a);
      #1;
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
         $display("Simulation failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic wait_load_idle();
      while (load_busy)
         step();
   endtask

   // the frame and fault are only valid while xlat_done is high.
   task automatic finish_translate(input logic [31:0] exp_paddr, input logic [31:0] exp_fault);
      check_value(32'(xlat_busy), 32'd1, "xlat_busy after xlat_strobe");
      while (!xlat_done)
         step();
      check_value(32'(xlat_busy), 32'd0, "xlat_busy with xlat_done");
      check_value(32'(xlat_paddr), exp_paddr, "xlat_paddr");
      check_value(32'(xlat_fault), exp_fault, "xlat_fault");
   endtask

   task automatic write_map_entry(input logic [31:0] page, input logic [31:0] entry);
      wait_load_idle();
      load_strobe = 1'b1;
      load_page   = page[page_bits-1:0];
      load_entry  = entry[vmem_pkg::entry_bits-1:0];
      step();
      load_strobe = 1'b0;
      check_value(32'(load_busy), 32'd1, "load_busy after load_strobe");
      wait_load_idle();
   endtask

   task automatic read_back_entry(input logic [31:0] page, input logic [31:0] exp_entry);
      rb_strobe = 1'b1;
      rb_page   = page[page_bits-1:0];
      step();
      rb_strobe = 1'b0;
      check_value(32'(rb_valid), 32'd1, "rb_valid one cycle after rb_strobe");
      check_value(32'(rb_entry), exp_entry, "rb_entry");
      step();
      check_value(32'(rb_valid), 32'd0, "rb_valid two cycles after rb_strobe");
   endtask

   task automatic start_translate(input logic [31:0] vaddr, input logic [31:0] write);
      xlat_strobe = 1'b1;
      xlat_vaddr  = vaddr[vaddr_bits-1:0];
      xlat_write  = write[0];
   endtask

   initial
   begin
      int          fd;
      int          status;
      string       line;
      logic [7:0]  op;
      logic [31:0] f1, f2, f3, f4, f5, f6;
      trace_loaded = 1'b0;
      reset        = 1'b1;
      load_strobe  = 1'b0;
      load_page    = '0;
      load_entry   = '0;
      rb_strobe    = 1'b0;
      rb_page      = '0;
      xlat_strobe  = 1'b0;
      xlat_vaddr   = '0;
      xlat_write   = 1'b0;
      fd = $fopen("sim/vmem_map_trace.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the trace file sim/vmem_map_trace.txt");
         $display("Simulation failed");
         $fatal(1, "no trace");
      end
      while (!$feof(fd))
      begin
         status = $fgets(line, fd);
         if (status != 0 && line.len() > 1 && line[0] != "#")
            ops.push_back(line);
      end
      $fclose(fd);
      trace_loaded = 1'b1;
      repeat (5) @(posedge clk_a);
      #1;
      reset = 1'b0;
      foreach (ops[i])
      begin
         status = $sscanf(ops[i], "%c %h %h %h %h %h %h", op, f1, f2, f3, f4, f5, f6);
         case (op)
            "L": write_map_entry(f1, f2);
            "R": read_back_entry(f1, f2);
            "T":
            begin
               start_translate(f1, f2);
               step();
               xlat_strobe = 1'b0;
               finish_translate(f3, f4);
            end
            "C":
            begin
               // load and lookup strobed on the same edge, so the arbiter sees both.
               load_strobe = 1'b1;
               load_page   = f1[page_bits-1:0];
               load_entry  = f2[vmem_pkg::entry_bits-1:0];
               start_translate(f3, f4);
               step();
               load_strobe = 1'b0;
               xlat_strobe = 1'b0;
               finish_translate(f5, f6);
               wait_load_idle();
            end
            default:
            begin
               $display("unknown operation in trace line: %s", ops[i]);
               $display("Simulation failed");
               $fatal(1, "bad trace");
            end
         endcase
      end
      $display("Simulation passed");
      $finish;
   end

   // each trace line gets 20 cycles, on top of the reset time.
   initial
   begin
      wait (trace_loaded === 1'b1);
      repeat (5 + 20 * ops.size()) @(posedge clk_a);
      $display("timeout: the trace did not finish within %0d cycles", 5 + 20 * ops.size());
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- sim/vmem_map_trace.txt
# L page entry | R page expected_entry | T vaddr write expected_paddr expected_fault
# C page entry vaddr write expected_paddr expected_fault (load and translate on one edge)
R 003 000000
L 005 C01234
R 005 C01234
T 0057F 0 12347F 0
T 00510 1 123410 0
L 006 802ABC
T 00620 0 2ABC20 0
T 00621 1 2ABC21 1
L 007 403FFF
T 00700 0 3FFF00 1
C 008 C00111 0057F 0 12347F 0
R 008 C00111
T 00805 1 011105 0
L 008 800222
R 008 800222
T 00833 1 022233 1

//--- source/vmem_arbiter.sv
`timescale 1ns/1ps

// shares memory port a between the map loader and the translator.
module vmem_arbiter
#(
   parameter int page_bits = vmem_pkg::default_page_bits
)
(
   input  logic                            clk_a,
   input  logic                            reset,
   input  logic                            wr_req,
   input  logic [page_bits-1:0]            wr_page,
   input  logic [vmem_pkg::entry_bits-1:0] wr_entry,
   input  logic                            rd_req,
   input  logic [page_bits-1:0]            rd_page,
   output logic                            wr_grant,
   output logic                            rd_grant,
   output logic [page_bits-1:0]            address_a,
   output logic [vmem_pkg::entry_bits-1:0] data_a,
   output logic                            wren_a,
   output logic                            rden_a
);

   logic last_rd; // set when the translator won the most recent grant.

   // a lone requester wins at once; on a tie the other side of last time wins.
   always_comb
   begin
      wr_grant = 1'b0;
      rd_grant = 1'b0;
      if (wr_req && rd_req)
      begin
         wr_grant = last_rd;
         rd_grant = !last_rd;
      end
      else
      begin
         wr_grant = wr_req;
         rd_grant = rd_req;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         last_rd <= 1'b0;
      end
      else if (rd_grant)
      begin
         last_rd <= 1'b1;
      end
      else if (wr_grant)
      begin
         last_rd <= 1'b0;
      end
   end

   // steer the winner onto port a.
   always_comb
   begin
      address_a = rd_grant ? rd_page : wr_page;
      data_a    = wr_entry;
      wren_a    = wr_grant;
      rden_a    = rd_grant;
   end

endmodule

//--- source/vmem_map_loader.sv
`timescale 1ns/1ps

// host write path into the map and the readback path on port b.
module vmem_map_loader
#(
   parameter int page_bits = vmem_pkg::default_page_bits
)
(
   input  logic                            clk_a,
   input  logic                            reset,
   input  logic                            load_strobe,
   input  logic [page_bits-1:0]            load_page,
   input  logic [vmem_pkg::entry_bits-1:0] load_entry,
   input  logic                            wr_grant,
   input  logic                            rb_strobe,
   input  logic [page_bits-1:0]            rb_page,
   input  logic [vmem_pkg::entry_bits-1:0] q_b,
   output logic                            load_busy,
   output logic                            wr_req,
   output logic [page_bits-1:0]            wr_page,
   output logic [vmem_pkg::entry_bits-1:0] wr_entry,
   output logic [page_bits-1:0]            address_b,
   output logic                            rden_b,
   output logic                            rb_valid,
   output logic [vmem_pkg::entry_bits-1:0] rb_entry
);

   // one-deep pending write; the host waits on load_busy before the next strobe.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         wr_req <= 1'b0;
      end
      else if (load_strobe)
      begin
         wr_req <= 1'b1;
      end
      else if (wr_grant)
      begin
         wr_req <= 1'b0;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (load_strobe)
      begin
         wr_page  <= load_page;
         wr_entry <= load_entry;
      end
   end

   assign load_busy = wr_req;

   // port b is private to the loader, so readback goes straight to it.
   assign address_b = rb_page;
   assign rden_b    = rb_strobe;
   assign rb_entry  = q_b;

   always_ff @(posedge clk_a)
   begin
      if (reset)
         rb_valid <= 1'b0;
      else
         rb_valid <= rb_strobe; // q_b is loaded on the same edge.
   end

endmodule

//--- source/vmem_map_ram.sv
`timescale 1ns/1ps

// map memory with one write/read port and one read-only port.
module vmem_map_ram
#(
   parameter int page_bits = vmem_pkg::default_page_bits
)
(
   input  logic                           clk_a,
   input  logic                           reset,
   input  logic [page_bits-1:0]           address_a,
   input  logic [vmem_pkg::entry_bits-1:0] data_a,
   input  logic                           wren_a,
   input  logic                           rden_a,
   input  logic [page_bits-1:0]           address_b,
   input  logic                           rden_b,
   output logic [vmem_pkg::entry_bits-1:0] q_a,
   output logic [vmem_pkg::entry_bits-1:0] q_b
);

   localparam int depth = 2 ** page_bits;

   logic [vmem_pkg::entry_bits-1:0] mem [depth];

   always_ff @(posedge clk_a)
   begin
      if (wren_a)
      begin
         mem[address_a] <= data_a;
      end
   end

   // reads see the old word when the same address is written in that cycle.
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_a <= '0;
      end
      else if (rden_a)
      begin
         q_a <= mem[address_a];
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         q_b <= '0;
      end
      else if (rden_b)
      begin
         q_b <= mem[address_b];
      end
   end

endmodule

//--- source/vmem_map_top.sv
`timescale 1ns/1ps

// first-level page map with loader and translator sharing the map memory.
module vmem_map_top
#(
   parameter int page_bits = vmem_pkg::default_page_bits
)
(
   input  logic                                                  clk_a,
   input  logic                                                  reset,
   input  logic                                                  load_strobe,
   input  logic [page_bits-1:0]                                  load_page,
   input  logic [vmem_pkg::entry_bits-1:0]                       load_entry,
   output logic                                                  load_busy,
   input  logic                                                  rb_strobe,
   input  logic [page_bits-1:0]                                  rb_page,
   output logic                                                  rb_valid,
   output logic [vmem_pkg::entry_bits-1:0]                       rb_entry,
   input  logic                                                  xlat_strobe,
   input  logic [page_bits+vmem_pkg::offset_bits-1:0]            xlat_vaddr,
   input  logic                                                  xlat_write,
   output logic                                                  xlat_busy,
   output logic                                                  xlat_done,
   output logic [vmem_pkg::frame_bits+vmem_pkg::offset_bits-1:0] xlat_paddr,
   output logic                                                  xlat_fault
);

   logic                            wr_req;
   logic                            wr_grant;
   logic [page_bits-1:0]            wr_page;
   logic [vmem_pkg::entry_bits-1:0] wr_entry;
   logic                            rd_req;
   logic                            rd_grant;
   logic [page_bits-1:0]            rd_page;
   logic [page_bits-1:0]            address_a;
   logic [vmem_pkg::entry_bits-1:0] data_a;
   logic                            wren_a;
   logic                            rden_a;
   logic [page_bits-1:0]            address_b;
   logic                            rden_b;
   logic [vmem_pkg::entry_bits-1:0] q_a;
   logic [vmem_pkg::entry_bits-1:0] q_b;

   vmem_map_ram #(.page_bits(page_bits)) i_vmem_map_ram (
      .clk_a(clk_a), .reset(reset),
      .address_a(address_a), .data_a(data_a), .wren_a(wren_a), .rden_a(rden_a),
      .address_b(address_b), .rden_b(rden_b),
      .q_a(q_a), .q_b(q_b)
   );

   vmem_arbiter #(.page_bits(page_bits)) i_vmem_arbiter (
      .clk_a(clk_a), .reset(reset),
      .wr_req(wr_req), .wr_page(wr_page), .wr_entry(wr_entry),
      .rd_req(rd_req), .rd_page(rd_page),
      .wr_grant(wr_grant), .rd_grant(rd_grant),
      .address_a(address_a), .data_a(data_a), .wren_a(wren_a), .rden_a(rden_a)
   );

   vmem_map_loader #(.page_bits(page_bits)) i_vmem_map_loader (
      .clk_a(clk_a), .reset(reset),
      .load_strobe(load_strobe), .load_page(load_page), .load_entry(load_entry),
      .wr_grant(wr_grant), .rb_strobe(rb_strobe), .rb_page(rb_page), .q_b(q_b),
      .load_busy(load_busy), .wr_req(wr_req), .wr_page(wr_page), .wr_entry(wr_entry),
      .address_b(address_b), .rden_b(rden_b),
      .rb_valid(rb_valid), .rb_entry(rb_entry)
   );

   vmem_translator #(.page_bits(page_bits)) i_vmem_translator (
      .clk_a(clk_a), .reset(reset),
      .xlat_strobe(xlat_strobe), .xlat_vaddr(xlat_vaddr), .xlat_write(xlat_write),
      .rd_grant(rd_grant), .q_a(q_a),
      .xlat_busy(xlat_busy), .rd_req(rd_req), .rd_page(rd_page),
      .xlat_done(xlat_done), .xlat_paddr(xlat_paddr), .xlat_fault(xlat_fault)
   );

endmodule

//--- source/vmem_pkg.sv
// shared sizes and entry layout for the first-level page map.
package vmem_pkg;

   // one map entry per virtual page.
   parameter int entry_bits = 24;

   // 10 page bits give a 1024-entry map.
   parameter int default_page_bits = 10;

   // byte offset within a page.
   parameter int offset_bits = 8;

   // physical frame number, held in the low bits of the entry.
   parameter int frame_bits = 14;

   // entry flag positions.
   parameter int valid_bit    = 23;
   parameter int write_ok_bit = 22;

endpackage

//--- source/vmem_translator.sv
`timescale 1ns/1ps

// looks up a virtual page in the map and forms the physical address.
module vmem_translator
#(
   parameter int page_bits = vmem_pkg::default_page_bits
)
(
   input  logic                                                clk_a,
   input  logic                                                reset,
   input  logic                                                xlat_strobe,
   input  logic [page_bits+vmem_pkg::offset_bits-1:0]          xlat_vaddr,
   input  logic                                                xlat_write,
   input  logic                                                rd_grant,
   input  logic [vmem_pkg::entry_bits-1:0]                     q_a,
   output logic                                                xlat_busy,
   output logic                                                rd_req,
   output logic [page_bits-1:0]                                rd_page,
   output logic                                                xlat_done,
   output logic [vmem_pkg::frame_bits+vmem_pkg::offset_bits-1:0] xlat_paddr,
   output logic                                                xlat_fault
);

   logic [vmem_pkg::offset_bits-1:0] offset; // in-page offset of the lookup.
   logic                             is_write;

   // page, offset and access type are held for the whole lookup.
   always_ff @(posedge clk_a)
   begin
      if (xlat_strobe)
      begin
         rd_page  <= xlat_vaddr[page_bits+vmem_pkg::offset_bits-1:vmem_pkg::offset_bits];
         offset   <= xlat_vaddr[vmem_pkg::offset_bits-1:0];
         is_write <= xlat_write;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         rd_req <= 1'b0;
      end
      else if (xlat_strobe)
      begin
         rd_req <= 1'b1;
      end
      else if (rd_grant)
      begin
         rd_req <= 1'b0;
      end
   end

   assign xlat_busy = rd_req;

   // the entry lands in q_a on the grant edge, so done follows the grant by one cycle.
   always_ff @(posedge clk_a)
   begin
      if (reset)
         xlat_done <= 1'b0;
      else
         xlat_done <= rd_grant;
   end

   assign xlat_paddr = {q_a[vmem_pkg::frame_bits-1:0], offset};

   // an invalid page faults, and so does a write to a page without write permit.
   assign xlat_fault = !q_a[vmem_pkg::valid_bit] ||
                       (is_write && !q_a[vmem_pkg::write_ok_bit]);

endmodule
